// File: hdl/mem_cfg_pkg.sv
// Sizing constants for the DRAM request scheduler
// Bank count, per-bank queue depths and count widths
// Address field and data widths, default drain watermarks
package mem_cfg_pkg;

  //**************************************************
  // Banks and queues
  //**************************************************
  localparam int NUM_BANKS = 16;
  localparam int BANK_BITS = $clog2(NUM_BANKS);      // 4

  localparam int RD_DEPTH  = 4;                      // Entries per read queue
  localparam int WR_DEPTH  = 6;                      // Entries per write queue

  // One bank's write occupancy, 0 to WR_DEPTH
  localparam int WR_CNT_BITS   = $clog2(WR_DEPTH + 1);               // 3
  // Sum over all banks, up to 96
  localparam int TOTAL_WR_BITS = $clog2(NUM_BANKS * WR_DEPTH + 1);   // 7

  //**************************************************
  // Address and data
  //**************************************************
  localparam int ROW_BITS  = 14;
  localparam int COL_BITS  = 10;
  localparam int DATA_BITS = 32;

  // Drain watermarks on the total write count
  localparam int DEF_LOW_WM  = 32;                   // About a third of full
  localparam int DEF_HIGH_WM = 64;                   // About two thirds of full

endpackage

// File: hdl/mem_req_pkg.sv
// Request and command formats for the DRAM request scheduler
// Opcode enum, host address and request structs
// Queue entry and DRAM command structs
package mem_req_pkg;

  // Access type, also used as the drain mode
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // Fixed bit-field address map, 28 bits
  typedef struct packed {
    logic [mem_cfg_pkg::BANK_BITS-1:0] bank;  // Top bits select the bank
    logic [mem_cfg_pkg::ROW_BITS-1:0]  row;
    logic [mem_cfg_pkg::COL_BITS-1:0]  col;
  } mem_addr_t;

  // Host request, 61 bits
  typedef struct packed {
    mem_op_e                           op;
    mem_addr_t                         addr;
    logic [mem_cfg_pkg::DATA_BITS-1:0] wdata;  // Ignored for reads
  } host_req_t;

  // One slot of a bank queue, bank and op are implied by the queue, 56 bits
  typedef struct packed {
    logic [mem_cfg_pkg::ROW_BITS-1:0]  row;
    logic [mem_cfg_pkg::COL_BITS-1:0]  col;
    logic [mem_cfg_pkg::DATA_BITS-1:0] wdata;
  } queue_entry_t;

  // Command toward the DRAM side, 61 bits
  typedef struct packed {
    mem_op_e                           op;
    logic [mem_cfg_pkg::BANK_BITS-1:0] bank;
    logic [mem_cfg_pkg::ROW_BITS-1:0]  row;
    logic [mem_cfg_pkg::COL_BITS-1:0]  col;
    logic [mem_cfg_pkg::DATA_BITS-1:0] wdata;
  } dram_cmd_t;

endpackage

// File: hdl/req_decoder.sv
// Host request decoder
// Registers the request, splits bank, row and column
// Steers a one-hot push to the read or write queue, drops on full
`timescale 1ns/1ns

module req_decoder (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                req_valid,   // One-cycle strobe
  input  mem_req_pkg::host_req_t              req,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0]   rd_full,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0]   wr_full,
  output logic [mem_cfg_pkg::NUM_BANKS-1:0]   rd_push,     // One-hot or zero
  output logic [mem_cfg_pkg::NUM_BANKS-1:0]   wr_push,
  output mem_req_pkg::queue_entry_t           push_entry,
  output logic                                req_drop     // Target queue was full
);
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;

  logic                 stg_valid;   // Request captured last cycle
  host_req_t            stg_req;
  logic [NUM_BANKS-1:0] bank_sel;    // Decoded bank
  logic                 tgt_full;    // Queue of the request's op is full

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stg_valid <= 1'b0;
    end else begin
      stg_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      stg_req <= req;                  // Payload only, no reset
    end
  end

  // Full is checked in the push cycle so earlier pushes are already counted
  always_comb begin
    bank_sel                   = '0;
    bank_sel[stg_req.addr.bank] = 1'b1;
    tgt_full = (stg_req.op == MEM_READ) ? rd_full[stg_req.addr.bank]
                                        : wr_full[stg_req.addr.bank];
    rd_push  = '0;
    wr_push  = '0;
    if (stg_valid && !tgt_full) begin
      if (stg_req.op == MEM_READ) rd_push = bank_sel;
      else                        wr_push = bank_sel;
    end
    req_drop = stg_valid && tgt_full;  // Pulse in place of the push
  end

  assign push_entry = '{row: stg_req.addr.row, col: stg_req.addr.col, wdata: stg_req.wdata};

  // One request per cycle reaches at most one queue of one bank
  a_push_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !((|rd_push) && (|wr_push)) && $onehot0(rd_push) && $onehot0(wr_push));

endmodule

// File: hdl/bank_queues.sv
// Per-bank request queues
// Circular read and write FIFOs for every bank
// Occupancy counts, empty and full flags, head entries
`timescale 1ns/1ns

module bank_queues #(
  parameter int RD_DEPTH = mem_cfg_pkg::RD_DEPTH,
  parameter int WR_DEPTH = mem_cfg_pkg::WR_DEPTH
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0]                      rd_push,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0]                      wr_push,
  input  mem_req_pkg::queue_entry_t                              push_entry,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0]                      rd_pop,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0]                      wr_pop,
  output mem_req_pkg::queue_entry_t [mem_cfg_pkg::NUM_BANKS-1:0] rd_head,
  output mem_req_pkg::queue_entry_t [mem_cfg_pkg::NUM_BANKS-1:0] wr_head,
  output logic [mem_cfg_pkg::NUM_BANKS-1:0]                      rd_empty,
  output logic [mem_cfg_pkg::NUM_BANKS-1:0]                      rd_full,
  output logic [mem_cfg_pkg::NUM_BANKS-1:0]                      wr_full,
  output logic [mem_cfg_pkg::NUM_BANKS-1:0][mem_cfg_pkg::WR_CNT_BITS-1:0] wr_count
);
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;

  localparam int RD_PTR_BITS = (RD_DEPTH > 1) ? $clog2(RD_DEPTH) : 1;
  localparam int WR_PTR_BITS = (WR_DEPTH > 1) ? $clog2(WR_DEPTH) : 1;
  localparam int RD_CNT_BITS = $clog2(RD_DEPTH + 1);

  //**************************************************
  // Storage and pointers
  //**************************************************
  queue_entry_t rd_mem [NUM_BANKS][RD_DEPTH];
  queue_entry_t wr_mem [NUM_BANKS][WR_DEPTH];

  logic [NUM_BANKS-1:0][RD_PTR_BITS-1:0] rd_wptr, rd_rptr;
  logic [NUM_BANKS-1:0][WR_PTR_BITS-1:0] wr_wptr, wr_rptr;
  logic [NUM_BANKS-1:0][RD_CNT_BITS-1:0] rd_cnt;   // Write side count is wr_count
  logic [NUM_BANKS-1:0]                  wr_empty; // No write queued in the bank

  // Entry write, a single entry bus serves all queues
  always_ff @(posedge clk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (rd_push[b]) rd_mem[b][rd_wptr[b]] <= push_entry;
      if (wr_push[b]) wr_mem[b][wr_wptr[b]] <= push_entry;
    end
  end

  // Read queues, pointers wrap at the depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_wptr <= '0;
      rd_rptr <= '0;
      rd_cnt  <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (rd_push[b]) rd_wptr[b] <= (rd_wptr[b] == RD_PTR_BITS'(RD_DEPTH - 1)) ? '0
                                                                                  : rd_wptr[b] + 1'b1;
        if (rd_pop[b])  rd_rptr[b] <= (rd_rptr[b] == RD_PTR_BITS'(RD_DEPTH - 1)) ? '0
                                                                                  : rd_rptr[b] + 1'b1;
        case ({rd_push[b], rd_pop[b]})
          2'b10:   rd_cnt[b] <= rd_cnt[b] + 1'b1;
          2'b01:   rd_cnt[b] <= rd_cnt[b] - 1'b1;
          default: rd_cnt[b] <= rd_cnt[b];        // Idle or push with pop
        endcase
      end
    end
  end

  // Write queues
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_wptr  <= '0;
      wr_rptr  <= '0;
      wr_count <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (wr_push[b]) wr_wptr[b] <= (wr_wptr[b] == WR_PTR_BITS'(WR_DEPTH - 1)) ? '0
                                                                                  : wr_wptr[b] + 1'b1;
        if (wr_pop[b])  wr_rptr[b] <= (wr_rptr[b] == WR_PTR_BITS'(WR_DEPTH - 1)) ? '0
                                                                                  : wr_rptr[b] + 1'b1;
        case ({wr_push[b], wr_pop[b]})
          2'b10:   wr_count[b] <= wr_count[b] + 1'b1;
          2'b01:   wr_count[b] <= wr_count[b] - 1'b1;
          default: wr_count[b] <= wr_count[b];
        endcase
      end
    end
  end

  //**************************************************
  // Flags and heads
  //**************************************************
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      rd_empty[b] = (rd_cnt[b] == '0);
      wr_empty[b] = (wr_count[b] == '0);
      rd_full[b]  = (rd_cnt[b] == RD_CNT_BITS'(RD_DEPTH));
      wr_full[b]  = (wr_count[b] == WR_CNT_BITS'(WR_DEPTH));
      rd_head[b]  = rd_mem[b][rd_rptr[b]];        // Valid only when not empty
      wr_head[b]  = wr_mem[b][wr_rptr[b]];
    end
  end

  // Decoder and scheduler must honor the flags
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    ((rd_push & rd_full) == '0) && ((wr_push & wr_full) == '0));
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    ((rd_pop & rd_empty) == '0) && ((wr_pop & wr_empty) == '0));

endmodule

// File: hdl/drain_mode_ctrl.sv
// Drain mode controller
// Sums the per-bank write counts into one total
// Two-state FSM that picks read or write drain against the watermarks
`timescale 1ns/1ns

module drain_mode_ctrl #(
  parameter int LOW_WM  = mem_cfg_pkg::DEF_LOW_WM,
  parameter int HIGH_WM = mem_cfg_pkg::DEF_HIGH_WM
) (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0]                             rd_empty,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0][mem_cfg_pkg::WR_CNT_BITS-1:0] wr_count,
  output mem_req_pkg::mem_op_e                                          mode
);
  import mem_cfg_pkg::*;

  localparam logic [TOTAL_WR_BITS-1:0] LOW_LIM  = TOTAL_WR_BITS'(LOW_WM);
  localparam logic [TOTAL_WR_BITS-1:0] HIGH_LIM = TOTAL_WR_BITS'(HIGH_WM);

  typedef enum logic {
    READ_DRAIN,
    WRITE_DRAIN
  } drain_state_e;

  drain_state_e             state, state_nxt;
  logic [TOTAL_WR_BITS-1:0] wr_total;   // Writes queued over all banks
  logic                     at_high;    // Total at or above high mark
  logic                     at_low;     // Total at or below low mark
  logic                     rd_idle;    // No read queued anywhere

  //**************************************************
  // Write total and watermark compares
  //**************************************************
  always_comb begin
    wr_total = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      wr_total = wr_total + TOTAL_WR_BITS'(wr_count[b]);
    end
  end

  assign at_high = (wr_total >= HIGH_LIM);
  assign at_low  = (wr_total <= LOW_LIM);
  assign rd_idle = &rd_empty;

  //**************************************************
  // Mode FSM
  //**************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) state <= READ_DRAIN;
    else        state <= state_nxt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      READ_DRAIN: begin
        if (at_high || (at_low && rd_idle)) state_nxt = WRITE_DRAIN;  // Too many writes or nothing to read
      end
      WRITE_DRAIN: begin
        if (at_low && !rd_idle) state_nxt = READ_DRAIN;  // Writes low again and reads wait
      end
      default: state_nxt = READ_DRAIN;
    endcase
  end

  assign mode = (state == WRITE_DRAIN) ? mem_req_pkg::MEM_WRITE : mem_req_pkg::MEM_READ;

  // A zero-width hysteresis band would let the mode toggle every cycle
  a_wm_order: assert property (@(posedge clk) LOW_WM < HIGH_WM);

endmodule

// File: hdl/bank_scheduler.sv
// Round-robin bank scheduler
// Picks the next bank with an entry of the current mode
// Pops its queue and registers the DRAM command, stalls on busy
`timescale 1ns/1ns

module bank_scheduler (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  mem_req_pkg::mem_op_e                                          mode,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0]                             rd_empty,
  input  logic [mem_cfg_pkg::NUM_BANKS-1:0][mem_cfg_pkg::WR_CNT_BITS-1:0] wr_count,
  input  mem_req_pkg::queue_entry_t [mem_cfg_pkg::NUM_BANKS-1:0]        rd_head,
  input  mem_req_pkg::queue_entry_t [mem_cfg_pkg::NUM_BANKS-1:0]        wr_head,
  input  logic                                                          dram_busy,
  output logic [mem_cfg_pkg::NUM_BANKS-1:0]                             rd_pop,
  output logic [mem_cfg_pkg::NUM_BANKS-1:0]                             wr_pop,
  output logic                                                          cmd_valid,
  output mem_req_pkg::dram_cmd_t                                        cmd
);
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;

  logic [BANK_BITS-1:0] rr_ptr;     // First bank to look at
  logic [NUM_BANKS-1:0] cand;       // Banks with work in the current mode
  logic                 found;
  logic [BANK_BITS-1:0] sel_bank;
  queue_entry_t         sel_entry;
  logic                 issue;      // Pop and load a command this cycle

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      cand[b] = (mode == MEM_READ) ? !rd_empty[b] : (wr_count[b] != '0);
    end
  end

  //**************************************************
  // Round-robin search from rr_ptr
  //**************************************************
  always_comb begin : rr_search
    logic [BANK_BITS-1:0] idx;
    found    = 1'b0;
    sel_bank = rr_ptr;
    for (int i = 0; i < NUM_BANKS; i++) begin
      idx = rr_ptr + BANK_BITS'(i);   // Wraps at NUM_BANKS
      if (!found && cand[idx]) begin
        found    = 1'b1;
        sel_bank = idx;
      end
    end
  end

  assign issue     = found && !dram_busy;
  assign sel_entry = (mode == MEM_READ) ? rd_head[sel_bank] : wr_head[sel_bank];

  always_comb begin
    rd_pop = '0;
    wr_pop = '0;
    if (issue) begin
      if (mode == MEM_READ) rd_pop[sel_bank] = 1'b1;
      else                  wr_pop[sel_bank] = 1'b1;
    end
  end

  //**************************************************
  // Command register
  //**************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
      rr_ptr    <= '0;
    end else if (!dram_busy) begin          // Busy freezes everything
      cmd_valid <= found;
      if (found) rr_ptr <= sel_bank + 1'b1; // Resume after the bank served
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      cmd <= '{op: mode, bank: sel_bank, row: sel_entry.row,
               col: sel_entry.col, wdata: sel_entry.wdata};
    end
  end

  // DRAM side sees a frozen command for the whole busy stretch
  a_hold_on_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (dram_busy && cmd_valid) |=> (cmd_valid && $stable(cmd)));

endmodule

// File: hdl/mem_sched_top.sv
// Request scheduler front end top level
// Decoder, bank queues, drain mode controller and bank scheduler
`timescale 1ns/1ns

module mem_sched_top #(
  parameter int LOW_WM   = mem_cfg_pkg::DEF_LOW_WM,
  parameter int HIGH_WM  = mem_cfg_pkg::DEF_HIGH_WM,
  parameter int RD_DEPTH = mem_cfg_pkg::RD_DEPTH,
  parameter int WR_DEPTH = mem_cfg_pkg::WR_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  mem_req_pkg::host_req_t req,
  input  logic                   dram_busy,   // Level from the DRAM side
  output logic                   req_drop,
  output mem_req_pkg::mem_op_e   mode,
  output logic                   cmd_valid,
  output mem_req_pkg::dram_cmd_t cmd
);
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;

  logic [NUM_BANKS-1:0]                  rd_push, wr_push, rd_pop, wr_pop;
  logic [NUM_BANKS-1:0]                  rd_empty, rd_full, wr_full;
  logic [NUM_BANKS-1:0][WR_CNT_BITS-1:0] wr_count;
  queue_entry_t                          push_entry;
  queue_entry_t [NUM_BANKS-1:0]          rd_head, wr_head;

  req_decoder u_decoder (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req(req),
    .rd_full(rd_full), .wr_full(wr_full), .rd_push(rd_push), .wr_push(wr_push),
    .push_entry(push_entry), .req_drop(req_drop)
  );

  bank_queues #(.RD_DEPTH(RD_DEPTH), .WR_DEPTH(WR_DEPTH)) u_queues (
    .clk(clk), .rst_n(rst_n), .rd_push(rd_push), .wr_push(wr_push),
    .push_entry(push_entry), .rd_pop(rd_pop), .wr_pop(wr_pop),
    .rd_head(rd_head), .wr_head(wr_head), .rd_empty(rd_empty),
    .rd_full(rd_full), .wr_full(wr_full), .wr_count(wr_count)
  );

  drain_mode_ctrl #(.LOW_WM(LOW_WM), .HIGH_WM(HIGH_WM)) u_mode (
    .clk(clk), .rst_n(rst_n), .rd_empty(rd_empty), .wr_count(wr_count), .mode(mode)
  );

  bank_scheduler u_sched (
    .clk(clk), .rst_n(rst_n), .mode(mode), .rd_empty(rd_empty), .wr_count(wr_count),
    .rd_head(rd_head), .wr_head(wr_head), .dram_busy(dram_busy),
    .rd_pop(rd_pop), .wr_pop(wr_pop), .cmd_valid(cmd_valid), .cmd(cmd)
  );

endmodule

// File: verification/clk_gen.sv
// Testbench clock and reset source
// Free-running clock, active-low reset held for a set number of cycles
`timescale 1ns/1ns

module clk_gen #(
  parameter int PERIOD     = 4,   // ns
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release right after a rising edge, DUT sees it on the next one
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: verification/mem_sched_tb.sv
// Testbench for the DRAM request scheduler front end
// Stimulus table with random addresses, per-bank queue model, drain mode model
// Compare tasks, watchdog and closing summary
`timescale 1ns/1ns

module mem_sched_tb;
  import mem_cfg_pkg::*;
  import mem_req_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RST_CYCLES   = 5;
  localparam int TB_LOW_WM    = 3;          // Small marks so the mode flips often
  localparam int TB_HIGH_WM   = 6;
  localparam int STIM_MAX     = 64;
  localparam int MAX_GAP      = 40;         // Longest idle stretch in the table
  localparam int DRAIN_CYCLES = NUM_BANKS * (RD_DEPTH + WR_DEPTH);

  typedef struct packed {
    host_req_t  req;
    logic       valid;                      // Strobe req_valid for this entry
    logic       busy;                       // dram_busy, held through the idle cycles
    logic [7:0] idle;                       // Quiet cycles after the entry
  } stim_t;

  logic      clk, rst_n;
  logic      req_valid, dram_busy;
  host_req_t req;
  logic      req_drop, cmd_valid;
  mem_op_e   mode;
  dram_cmd_t cmd;

  stim_t stim [STIM_MAX];
  int    n_stim      = 0;
  logic  table_built = 1'b0;
  int    seed        = 32'h3de1_1432;

  //**************************************************
  // Reference model state
  //**************************************************
  queue_entry_t rd_q [NUM_BANKS][$];
  queue_entry_t wr_q [NUM_BANKS][$];
  mem_op_e      exp_mode   = MEM_READ;      // Mode expected in the current cycle
  mem_op_e      issue_mode = MEM_READ;      // Model mode one negedge back
  logic         issue_q    = 1'b0;          // Work was queued for the mode last cycle
  logic         busy_q     = 1'b0;          // Values seen one negedge back
  logic         valid_q    = 1'b0;
  dram_cmd_t    cmd_q;
  mem_op_e      mode_q     = MEM_READ;
  logic         d1_valid   = 1'b0;          // Request now in the decoder push cycle
  host_req_t    d1_req;

  int errors        = 0;
  int n_accepted    = 0;
  int n_dropped     = 0;
  int n_drop_pulses = 0;                    // req_drop pulses seen on the DUT
  int n_issued      = 0;

  clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) clk_gen_i (.clk(clk), .rst_n(rst_n));

  mem_sched_top #(.LOW_WM(TB_LOW_WM), .HIGH_WM(TB_HIGH_WM)) dut_i (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req(req), .dram_busy(dram_busy),
    .req_drop(req_drop), .mode(mode), .cmd_valid(cmd_valid), .cmd(cmd)
  );

  //**************************************************
  // Compare tasks
  //**************************************************
  task automatic check_cmd(input dram_cmd_t act, input dram_cmd_t exp, input string what);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_mode(input mem_op_e act, input mem_op_e exp, input string what);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s, got %s expected %s", $time, what, act.name(), exp.name());
    end
  endtask

  task automatic check_drop(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s, got %b expected %b", $time, what, act, exp);
    end
  endtask

  task automatic check_valid(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s, cmd_valid got %b expected %b", $time, what, act, exp);
    end
  endtask

  // Queue totals of the model
  function automatic int read_total();
    int n = 0;
    for (int b = 0; b < NUM_BANKS; b++) n += rd_q[b].size();
    return n;
  endfunction

  function automatic int write_total();
    int n = 0;
    for (int b = 0; b < NUM_BANKS; b++) n += wr_q[b].size();
    return n;
  endfunction

  // Drain mode rule with hysteresis between the two marks
  function automatic mem_op_e next_mode(input mem_op_e cur, input int total, input logic rd_pend);
    if (cur == MEM_READ) begin
      if (total >= TB_HIGH_WM || (total <= TB_LOW_WM && !rd_pend)) return MEM_WRITE;
    end else if (total <= TB_LOW_WM && rd_pend) begin
      return MEM_READ;
    end
    return cur;
  endfunction

  //**************************************************
  // Stimulus table
  //**************************************************
  task automatic add_entry(input logic valid, input mem_op_e op, input int bank,
                           input logic busy, input int idle);
    stim_t s;
    s.req.op        = op;
    s.req.addr.bank = BANK_BITS'(bank);
    s.req.addr.row  = ROW_BITS'($random(seed));   // Random row, column and data
    s.req.addr.col  = COL_BITS'($random(seed));
    s.req.wdata     = $random(seed);
    s.valid         = valid;
    s.busy          = busy;
    s.idle          = 8'(idle);
    stim[n_stim]    = s;
    n_stim++;
  endtask

  task automatic build_table();
    int r;
    for (int i = 0; i < 16; i++) begin            // Mixed warm-up traffic
      r = $random(seed);
      add_entry(1'b1, mem_op_e'(r[4]), int'(r[3:0]), 1'b0, int'(r[9:8]) % 3);
    end
    for (int i = 0; i < 3; i++) add_entry(1'b1, MEM_READ, 2, 1'b0, 0);  // cmd_valid up
    for (int i = 0; i < 5; i++) add_entry(1'b1, MEM_READ, 3, 1'b1, 0);  // Fifth read drops
    for (int i = 0; i < 7; i++) add_entry(1'b1, MEM_WRITE, 5, 1'b1, 0); // Seventh write drops
    add_entry(1'b0, MEM_READ, 0, 1'b0, 10);       // Busy released
    for (int i = 0; i < 20; i++) begin            // Random traffic with busy spells
      r = $random(seed);
      add_entry(1'b1, mem_op_e'(r[4]), int'(r[3:0]), r[11:10] == 2'd0, int'(r[12]));
    end
    add_entry(1'b0, MEM_READ, 0, 1'b0, MAX_GAP);  // Let the reads run dry
    // Closing write burst pushes the total past the high mark
    for (int i = 0; i < 8; i++) add_entry(1'b1, MEM_WRITE, i, 1'b0, 0);
  endtask

  //**************************************************
  // Monitor and model update, mid-cycle
  //**************************************************
  always @(negedge clk) begin : monitor
    queue_entry_t head;
    dram_cmd_t    exp_cmd;
    logic         have_head;
    logic         full;
    logic         rd_pend;
    if (rst_n) begin
      if (busy_q) begin                           // Register frozen, no pop
        check_valid(cmd_valid, valid_q, "hold on busy");
        if (valid_q) check_cmd(cmd, cmd_q, "cmd held on busy");
      end else begin
        check_valid(cmd_valid, issue_q, "command issue");
        if (cmd_valid) begin
          n_issued++;
          check_mode(cmd.op, mode_q, "command op against mode at issue");
          have_head = 1'b1;
          if (issue_mode == MEM_READ && rd_q[cmd.bank].size() != 0) begin
            head = rd_q[cmd.bank].pop_front();
          end else if (issue_mode == MEM_WRITE && wr_q[cmd.bank].size() != 0) begin
            head = wr_q[cmd.bank].pop_front();
          end else begin
            have_head = 1'b0;
            errors++;
            $display("Command at %0t ns for bank %0d has no accepted request behind it",
                     $time, cmd.bank);
          end
          if (have_head) begin
            exp_cmd = '{op: issue_mode, bank: cmd.bank, row: head.row, col: head.col,
                        wdata: head.wdata};
            check_cmd(cmd, exp_cmd, "command against model queue head");
          end
        end
      end
      check_mode(mode, exp_mode, "drain mode");
      issue_mode = exp_mode;                      // Op of a command loaded at the next edge
      rd_pend    = (read_total() != 0);
      issue_q    = (exp_mode == MEM_READ) ? rd_pend : (write_total() != 0);
      exp_mode   = next_mode(exp_mode, write_total(), rd_pend);
      full       = 1'b0;                          // Occupancy at the start of the push cycle
      if (d1_valid) begin
        if (d1_req.op == MEM_READ) full = (rd_q[d1_req.addr.bank].size() >= RD_DEPTH);
        else                       full = (wr_q[d1_req.addr.bank].size() >= WR_DEPTH);
        head = '{row: d1_req.addr.row, col: d1_req.addr.col, wdata: d1_req.wdata};
        if (full) begin
          n_dropped++;
        end else begin
          n_accepted++;
          if (d1_req.op == MEM_READ) rd_q[d1_req.addr.bank].push_back(head);
          else                       wr_q[d1_req.addr.bank].push_back(head);
        end
      end
      check_drop(req_drop, full, "req_drop");
      if (req_drop === 1'b1) n_drop_pulses++;
      busy_q   = dram_busy;
      valid_q  = cmd_valid;
      cmd_q    = cmd;
      mode_q   = mode;
      d1_valid = req_valid;                       // Captured by the decoder next edge
      d1_req   = req;
    end
  end

  //**************************************************
  // Stimulus, drain and summary
  //**************************************************
  initial begin : stimulus
    req_valid   = 1'b0;
    req         = '0;
    dram_busy   = 1'b0;
    build_table();
    table_built = 1'b1;
    wait (rst_n === 1'b1);
    for (int i = 0; i < n_stim; i++) begin
      @(posedge clk);
      req_valid <= stim[i].valid;
      req       <= stim[i].req;
      dram_busy <= stim[i].busy;
      for (int k = 0; k < int'(stim[i].idle); k++) begin
        @(posedge clk);
        req_valid <= 1'b0;
      end
    end
    @(posedge clk);
    req_valid <= 1'b0;
    dram_busy <= 1'b0;
    while (read_total() + write_total() != 0 || d1_valid) @(posedge clk);
    repeat (8) @(posedge clk);                    // No stray command may follow
    if (n_issued != n_accepted) begin
      errors++;
      $display("[ERROR] %0t ns: %0d commands issued for %0d accepted requests",
               $time, n_issued, n_accepted);
    end
    if (n_drop_pulses != n_dropped) begin
      errors++;
      $display("[ERROR] %0t ns: %0d req_drop pulses for %0d requests to full queues",
               $time, n_drop_pulses, n_dropped);
    end
    $display("Summary: %0d errors, %0d accepted, %0d dropped, %0d issued",
             errors, n_accepted, n_dropped, n_issued);
    if (errors == 0) $display("ALL CHECKS PASSED");
    else             $display("CHECKS FAILED");
    $finish;
  end

  // Limit from table length at the longest gap plus a full drain of every queue
  initial begin : watchdog
    longint limit_cycles;
    wait (table_built);
    limit_cycles = RST_CYCLES + n_stim * (MAX_GAP + 1) + 2 * DRAIN_CYCLES;
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout: queues not drained after %0d cycles", limit_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: compile.f
hdl/mem_cfg_pkg.sv
hdl/mem_req_pkg.sv
hdl/req_decoder.sv
hdl/bank_queues.sv
hdl/drain_mode_ctrl.sv
hdl/bank_scheduler.sv
hdl/mem_sched_top.sv
verification/clk_gen.sv
verification/mem_sched_tb.sv

// File: Makefile
# Verilator build and run of the DRAM request scheduler testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= mem_sched_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Output goes to the terminal and through grep, the grep status decides pass or fail
test: $(SIM_BIN)
	./$(SIM_BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
